/* design/pma_pkg.sv */
package pma_pkg;

  // ------------------------------------------------------------------
  // TBI code group
  // ------------------------------------------------------------------

  localparam int TBI_WIDTH = 10;              // One 8b/10b code group

  typedef logic [TBI_WIDTH-1:0] tbi_word_t;   // Raw TBI word, bit 0 first on the PCS side

  // ------------------------------------------------------------------
  // LVDS receiver reset sequencer
  // ------------------------------------------------------------------

  // Sequencer states in the order they are walked
  typedef enum logic [2:0]
  {
    SEQ_PLL_RESET,    // Receive PLL held in reset
    SEQ_WAIT_LOCK,    // Waiting for a stable lock window
    SEQ_CDA_RESET,    // Single cycle aligner reset
    SEQ_ALIGN_PULSE,  // Word align strobe
    SEQ_ALIGN_GAP,    // Quiet cycles between strobes
    SEQ_DONE          // Receiver up and aligned
  } seq_state_t;

  // Wait lengths, all in ref_clk cycles
  localparam int PLL_RESET_CYCLES   = 8;   // pll_areset hold time
  localparam int LOCK_STABLE_CYCLES = 16;  // Consecutive locked cycles needed
  localparam int ALIGN_GAP_CYCLES   = 4;   // Low cycles after each align strobe
  localparam int ALIGN_PULSES       = 4;   // Align strobes per sequence

  // Timer sized for the longest wait
  localparam int TIMER_WIDTH = 5;

  typedef logic [TIMER_WIDTH-1:0] timer_count_t;

endpackage

/* design/lvds_ctrl_if.sv */
interface lvds_ctrl_if;

  logic pll_areset;             // Receive PLL reset
  logic rx_reset;               // Digital reset of the receive side
  logic rx_cda_reset;           // Channel data aligner reset
  logic rx_channel_data_align;  // Word align strobe
  logic rx_locked;              // PLL lock from the deserializer
  logic seq_done;               // Sequence finished, words aligned

  // Sequencer owns the control levels
  modport seq (
    output pll_areset, rx_reset, rx_cda_reset, rx_channel_data_align, seq_done,
    input  rx_locked
  );

  // Receive path only gates on done
  modport rx (
    input seq_done
  );

  // Top level breaks the bundle out to pins
  modport top (
    output rx_locked,
    input  pll_areset, rx_reset, rx_cda_reset, rx_channel_data_align, seq_done
  );

endinterface

/* design/seq_timer.sv */
module seq_timer (
  input  logic                 ref_clk,
  input  logic                 reset_ref_clk_int,
  input  logic                 load,        // Start a new wait
  input  pma_pkg::timer_count_t load_value, // Cycles to wait minus one
  output logic                 expired      // Count has run down
);

  import pma_pkg::*;

  timer_count_t count_q;  // Remaining cycles

  // ------------------------------------------------------------------
  // Down-counter
  // ------------------------------------------------------------------

  // Out of reset the PLL hold wait is already running
  // expired is kept equal to (count_q == 0) but comes from a flop
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      count_q <= timer_count_t'(PLL_RESET_CYCLES - 1);
      expired <= 1'b0;
    end
    else if (load)
    begin
      count_q <= load_value;                // Reload wins over counting
      expired <= (load_value == '0);
    end
    else if (count_q != '0)
    begin
      count_q <= count_q - 1'b1;
      expired <= (count_q == timer_count_t'(1));  // Last step to zero
    end
    // At zero both hold until the next load
  end

endmodule

/* design/lvds_reset_sequencer.sv */
module lvds_reset_sequencer (
  input  logic                  ref_clk,
  input  logic                  reset_ref_clk_int,
  lvds_ctrl_if.seq              ctrl,
  output logic                  timer_load,    // Restart the wait timer
  output pma_pkg::timer_count_t timer_value,   // Wait length minus one
  input  logic                  timer_expired  // Current wait is over
);

  import pma_pkg::*;

  seq_state_t   state_q;
  seq_state_t   state_d;
  timer_count_t pulse_cnt_q;  // Align strobes issued so far
  logic         lock_lost;    // Lock dropped after the stable window

  // ------------------------------------------------------------------
  // Lock supervision
  // ------------------------------------------------------------------

  // Only checked once the lock window has been passed
  assign lock_lost = !ctrl.rx_locked &&
                     (state_q inside {SEQ_CDA_RESET, SEQ_ALIGN_PULSE,
                                      SEQ_ALIGN_GAP, SEQ_DONE});

  // ------------------------------------------------------------------
  // Next state and timer control
  // ------------------------------------------------------------------

  always_comb
  begin
    state_d     = state_q;
    timer_load  = 1'b0;
    timer_value = timer_count_t'(LOCK_STABLE_CYCLES - 1);  // Most loads are the lock window

    case (state_q)
      SEQ_PLL_RESET:
      begin
        if (timer_expired)
        begin
          state_d    = SEQ_WAIT_LOCK;
          timer_load = 1'b1;           // Open the first lock window
        end
      end

      SEQ_WAIT_LOCK:
      begin
        if (!ctrl.rx_locked)
          timer_load = 1'b1;           // Glitch, start the window over
        else if (timer_expired)
          state_d = SEQ_CDA_RESET;     // Locked for the whole window
      end

      SEQ_CDA_RESET:
        state_d = SEQ_ALIGN_PULSE;

      SEQ_ALIGN_PULSE:
      begin
        state_d     = SEQ_ALIGN_GAP;
        timer_load  = 1'b1;
        timer_value = timer_count_t'(ALIGN_GAP_CYCLES - 1);
      end

      SEQ_ALIGN_GAP:
      begin
        if (timer_expired)
        begin
          // Another strobe or finish
          if (pulse_cnt_q == timer_count_t'(ALIGN_PULSES))
            state_d = SEQ_DONE;
          else
            state_d = SEQ_ALIGN_PULSE;
        end
      end

      SEQ_DONE:
        state_d = SEQ_DONE;            // Parked until lock drops

      default:
        state_d = SEQ_PLL_RESET;       // Illegal encoding, start from the top
    endcase

    // Lock loss beats any other transition
    if (lock_lost)
    begin
      state_d     = SEQ_WAIT_LOCK;
      timer_load  = 1'b1;
      timer_value = timer_count_t'(LOCK_STABLE_CYCLES - 1);
    end
  end

  // ------------------------------------------------------------------
  // State and strobe counter
  // ------------------------------------------------------------------

  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
      state_q <= SEQ_PLL_RESET;
    else
      state_q <= state_d;
  end

  // Cleared while waiting for lock so every pass issues the full set
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
      pulse_cnt_q <= '0;
    else if (state_q == SEQ_WAIT_LOCK)
      pulse_cnt_q <= '0;
    else if (state_q == SEQ_ALIGN_PULSE)
      pulse_cnt_q <= pulse_cnt_q + 1'b1;  // One per strobe
  end

  // ------------------------------------------------------------------
  // Moore outputs
  // ------------------------------------------------------------------

  assign ctrl.pll_areset            = (state_q == SEQ_PLL_RESET);
  assign ctrl.rx_reset              = (state_q == SEQ_PLL_RESET) ||
                                      (state_q == SEQ_WAIT_LOCK);  // Low from CDA reset on
  assign ctrl.rx_cda_reset          = (state_q == SEQ_CDA_RESET);
  assign ctrl.rx_channel_data_align = (state_q == SEQ_ALIGN_PULSE);
  assign ctrl.seq_done              = (state_q == SEQ_DONE);

endmodule

/* design/tbi_rx_path.sv */
module tbi_rx_path (
  input  logic              ref_clk,
  input  logic              reset_ref_clk_int,
  lvds_ctrl_if.rx           ctrl,
  input  pma_pkg::tbi_word_t rx_word_lvds,  // Deserializer word, bit 9 first
  output pma_pkg::tbi_word_t tbi_rx_d       // PCS word, bit 0 first
);

  // ------------------------------------------------------------------
  // Receive word capture
  // ------------------------------------------------------------------

  // The LVDS deserializer shifts bit 9 in first while Clause 36
  // wants bit 0 first, so the whole word is mirrored here.
  // Capture is held off until the aligner has finished so the PCS
  // never sees a word taken across a bit slip.
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
      tbi_rx_d <= '0;
    else if (ctrl.seq_done)
      tbi_rx_d <= {<<{rx_word_lvds}};  // Mirror bits 9..0
    // Last aligned word holds until done
  end

endmodule

/* design/tbi_tx_path.sv */
module tbi_tx_path (
  input  logic               ref_clk,
  input  logic               reset_ref_clk_int,
  input  pma_pkg::tbi_word_t tbi_tx_d,          // PCS word, bit 0 first
  input  pma_pkg::tbi_word_t rx_word_lvds,      // Raw deserializer word
  input  logic               rev_loopback_ena,  // Send received data back out
  output pma_pkg::tbi_word_t tx_word_lvds       // Serializer word, bit 9 first
);

  import pma_pkg::*;

  tbi_word_t tx_flip_q;  // Mirrored PCS word
  tbi_word_t loop_q;     // Received word for reverse loopback

  // ------------------------------------------------------------------
  // Transmit mirror
  // ------------------------------------------------------------------

  // Serializer sends bit 9 first, PCS puts bit 0 first
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
      tx_flip_q <= '0;
    else
      tx_flip_q <= {<<{tbi_tx_d}};
  end

  // ------------------------------------------------------------------
  // Reverse loopback
  // ------------------------------------------------------------------

  // Already in serializer bit order, so no mirror on this leg
  // Single stage since both sides run on ref_clk
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
      loop_q <= '0;
    else
      loop_q <= rx_word_lvds;
  end

  // Select after the flops so a toggle takes effect at once
  assign tx_word_lvds = rev_loopback_ena ? loop_q : tx_flip_q;

endmodule

/* design/lvds_pma_top.sv */
module lvds_pma_top (
  input  logic               ref_clk,
  input  logic               reset_ref_clk_int,
  input  logic               rx_locked,               // From the LVDS receive PLL
  input  pma_pkg::tbi_word_t rx_word_lvds,            // Parallel word from the deserializer
  input  pma_pkg::tbi_word_t tbi_tx_d,                // Transmit word from the PCS
  input  logic               rev_loopback_ena,
  output logic               pll_areset,
  output logic               rx_reset,
  output logic               rx_cda_reset,
  output logic               rx_channel_data_align,
  output logic               rx_reset_sequence_done,
  output pma_pkg::tbi_word_t tbi_rx_d,                // Receive word to the PCS
  output pma_pkg::tbi_word_t tx_word_lvds             // Parallel word to the serializer
);

  import pma_pkg::*;

  lvds_ctrl_if ctrl_if ();

  logic         timer_load;
  timer_count_t timer_value;
  logic         timer_expired;

  // ------------------------------------------------------------------
  // Receiver control breakout
  // ------------------------------------------------------------------

  assign ctrl_if.rx_locked = rx_locked;

  assign pll_areset             = ctrl_if.pll_areset;
  assign rx_reset               = ctrl_if.rx_reset;
  assign rx_cda_reset           = ctrl_if.rx_cda_reset;
  assign rx_channel_data_align  = ctrl_if.rx_channel_data_align;
  assign rx_reset_sequence_done = ctrl_if.seq_done;  // Also gates the receive path

  // ------------------------------------------------------------------
  // Reset sequencer and its wait timer
  // ------------------------------------------------------------------

  seq_timer i_seq_timer (
    .ref_clk           (ref_clk),
    .reset_ref_clk_int (reset_ref_clk_int),
    .load              (timer_load),
    .load_value        (timer_value),
    .expired           (timer_expired)
  );

  lvds_reset_sequencer i_lvds_reset_sequencer (
    .ref_clk           (ref_clk),
    .reset_ref_clk_int (reset_ref_clk_int),
    .ctrl              (ctrl_if.seq),
    .timer_load        (timer_load),
    .timer_value       (timer_value),
    .timer_expired     (timer_expired)
  );

  // ------------------------------------------------------------------
  // Data paths
  // ------------------------------------------------------------------

  tbi_rx_path i_tbi_rx_path (
    .ref_clk           (ref_clk),
    .reset_ref_clk_int (reset_ref_clk_int),
    .ctrl              (ctrl_if.rx),
    .rx_word_lvds      (rx_word_lvds),
    .tbi_rx_d          (tbi_rx_d)
  );

  tbi_tx_path i_tbi_tx_path (
    .ref_clk           (ref_clk),
    .reset_ref_clk_int (reset_ref_clk_int),
    .tbi_tx_d          (tbi_tx_d),
    .rx_word_lvds      (rx_word_lvds),     // Raw word feeds the loopback leg
    .rev_loopback_ena  (rev_loopback_ena),
    .tx_word_lvds      (tx_word_lvds)
  );

endmodule

/* bench/tb_lvds_pma.sv */
module tb_lvds_pma;

  import pma_pkg::*;

  // Hard stop well beyond the full stimulus sequence
  localparam int TIMEOUT_CYCLES = 3000;

  logic      ref_clk;
  logic      reset_ref_clk_int;
  logic      rx_locked;
  tbi_word_t rx_word_lvds;
  tbi_word_t tbi_tx_d;
  logic      rev_loopback_ena;
  logic      pll_areset;
  logic      rx_reset;
  logic      rx_cda_reset;
  logic      rx_channel_data_align;
  logic      rx_reset_sequence_done;
  tbi_word_t tbi_rx_d;
  tbi_word_t tx_word_lvds;

  integer    seed;           // $random state
  int        cycle_cnt = 0;  // Timeout counter

  // Reference model state
  tbi_word_t model_flip;     // Expected mirrored transmit word
  tbi_word_t model_loop;     // Expected loopback word
  tbi_word_t model_rx;       // Expected receive capture
  int        pll_high_cnt;   // Edges with pll_areset high
  logic      pll_released;   // pll_areset has dropped once
  int        lock_run;       // Consecutive locked edges in the lock wait
  int        align_cnt;      // Align strobes since the last CDA reset
  int        gap_cnt;        // Low cycles since the last align strobe

  lvds_pma_top i_dut (
    .ref_clk                (ref_clk),
    .reset_ref_clk_int      (reset_ref_clk_int),
    .rx_locked              (rx_locked),
    .rx_word_lvds           (rx_word_lvds),
    .tbi_tx_d               (tbi_tx_d),
    .rev_loopback_ena       (rev_loopback_ena),
    .pll_areset             (pll_areset),
    .rx_reset               (rx_reset),
    .rx_cda_reset           (rx_cda_reset),
    .rx_channel_data_align  (rx_channel_data_align),
    .rx_reset_sequence_done (rx_reset_sequence_done),
    .tbi_rx_d               (tbi_rx_d),
    .tx_word_lvds           (tx_word_lvds)
  );

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  // Bit 0 swaps with bit 9 and so on
  function automatic tbi_word_t mirror_word(input tbi_word_t w);
    tbi_word_t r;
    for (int i = 0; i < TBI_WIDTH; i++)
      r[i] = w[TBI_WIDTH-1-i];
    return r;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // One clock of stimulus with fresh random data
  task automatic step_cycle(input logic lock);
    @(posedge ref_clk);
    rx_locked    <= lock;
    rx_word_lvds <= tbi_word_t'($random(seed));
    tbi_tx_d     <= tbi_word_t'($random(seed));
    if (($random(seed) & 7) == 0)
      rev_loopback_ena <= !rev_loopback_ena;  // Toggle about one cycle in eight
  endtask

  // Short lock bursts well below the stable window
  task automatic lock_glitches(input int count);
    int high_len;
    int low_len;
    for (int n = 0; n < count; n++)
    begin
      high_len = 2 + ($random(seed) & 7);  // 2 to 9 cycles
      low_len  = 1 + ($random(seed) & 1);
      repeat (high_len) step_cycle(1'b1);
      repeat (low_len) step_cycle(1'b0);
    end
  endtask

  task automatic hold_lock(input int cycles);
    repeat (cycles) step_cycle(1'b1);
  endtask

  task automatic run_until_done();
    while (!rx_reset_sequence_done)
      step_cycle(1'b1);
  endtask

  task automatic wait_for_align();
    while (!rx_channel_data_align)
      step_cycle(1'b1);
  endtask

  // ------------------------------------------------------------------
  // Clock, timeout and stimulus
  // ------------------------------------------------------------------

  initial
  begin
    ref_clk = 1'b0;
    forever #50 ref_clk = ~ref_clk;
  end

  always @(posedge ref_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      fail_now("Run exceeded the cycle limit before the test sequence ended");
  end

  initial
  begin
    seed              = 71;
    reset_ref_clk_int = 1'b1;
    rx_locked         = 1'b0;
    rx_word_lvds      = '0;
    tbi_tx_d          = '0;
    rev_loopback_ena  = 1'b0;
    repeat (5) @(posedge ref_clk);
    reset_ref_clk_int <= 1'b0;

    repeat (12) step_cycle(1'b0);  // PLL hold, no lock yet
    lock_glitches(6);
    run_until_done();
    hold_lock(40);                 // Aligned traffic, loopback toggling

    // Lock lost while done
    step_cycle(1'b0);
    lock_glitches(3);
    run_until_done();
    hold_lock(30);

    // Lock lost in the middle of alignment
    step_cycle(1'b0);
    wait_for_align();
    hold_lock(3);
    repeat (2) step_cycle(1'b0);
    run_until_done();
    hold_lock(30);

    $display("Finished with no errors");
    $finish;
  end

  // ------------------------------------------------------------------
  // Reference model and sequence monitors
  // ------------------------------------------------------------------

  always @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      model_flip   <= '0;
      model_loop   <= '0;
      model_rx     <= '0;
      pll_high_cnt <= 0;
      pll_released <= 1'b0;
      lock_run     <= 0;
      align_cnt    <= 0;
      gap_cnt      <= 0;
    end
    else
    begin
      model_flip <= mirror_word(tbi_tx_d);
      model_loop <= rx_word_lvds;              // Loopback leg is not mirrored
      if (rx_reset_sequence_done)
        model_rx <= mirror_word(rx_word_lvds);
      if (pll_areset)
        pll_high_cnt <= pll_high_cnt + 1;
      else
        pll_released <= 1'b1;
      // Lock wait is the only state with rx_reset high and PLL running
      if (rx_reset && !pll_areset && rx_locked)
        lock_run <= lock_run + 1;
      else
        lock_run <= 0;
      if (rx_cda_reset)
      begin
        align_cnt <= 0;
        gap_cnt   <= 0;
      end
      else if (rx_channel_data_align)
      begin
        align_cnt <= align_cnt + 1;
        gap_cnt   <= 0;
      end
      else
        gap_cnt <= gap_cnt + 1;
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  reset_levels: assert property (@(posedge ref_clk)
    $fell(reset_ref_clk_int) |-> pll_areset && rx_reset && !rx_cda_reset &&
      !rx_channel_data_align && !rx_reset_sequence_done && tbi_rx_d == '0 &&
      tx_word_lvds == '0)
    else fail_now("Outputs were not at their reset levels when reset was released");

  pll_hold_length: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    $fell(pll_areset) |-> pll_high_cnt == PLL_RESET_CYCLES)
    else fail_now($sformatf("mismatch pll_areset high cycles: got %h, expected %h",
                            $sampled(pll_high_cnt), PLL_RESET_CYCLES));

  pll_single_shot: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    pll_released |-> !pll_areset)
    else fail_now("pll_areset was asserted again after its first release");

  pll_hold_levels: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    pll_areset |-> rx_reset && !rx_reset_sequence_done && !rx_cda_reset)
    else fail_now("rx_reset low or done high while pll_areset was held");

  lock_window: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    $rose(rx_cda_reset) |-> lock_run == LOCK_STABLE_CYCLES)
    else fail_now($sformatf("mismatch locked cycles before rx_cda_reset: got %h, expected %h",
                            $sampled(lock_run), LOCK_STABLE_CYCLES));

  cda_one_cycle: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    rx_cda_reset |=> !rx_cda_reset)
    else fail_now("rx_cda_reset stayed high for more than one cycle");

  cda_releases_rx: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    rx_cda_reset |-> !rx_reset)
    else fail_now("rx_reset was still high during the rx_cda_reset pulse");

  rx_reset_stays_low: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    !rx_reset && rx_locked |=> !rx_reset)
    else fail_now("rx_reset rose while lock was held after the CDA reset");

  lock_loss_restart: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    !rx_reset && !rx_locked |=> rx_reset && !rx_reset_sequence_done)
    else fail_now("Loss of lock did not send the sequencer back to the lock wait");

  align_one_cycle: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    rx_channel_data_align |=> !rx_channel_data_align)
    else fail_now("rx_channel_data_align stayed high for more than one cycle");

  align_first_after_cda: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    $rose(rx_channel_data_align) && align_cnt == 0 |-> $past(rx_cda_reset))
    else fail_now("First align pulse did not directly follow rx_cda_reset");

  align_spacing: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    $rose(rx_channel_data_align) && align_cnt != 0 |-> gap_cnt >= ALIGN_GAP_CYCLES)
    else fail_now($sformatf("mismatch align gap cycles: got %h, expected at least %h",
                            $sampled(gap_cnt), ALIGN_GAP_CYCLES));

  align_limit: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    rx_channel_data_align |-> align_cnt < ALIGN_PULSES)
    else fail_now("More align pulses than expected in one sequence");

  done_after_align: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    $rose(rx_reset_sequence_done) |-> align_cnt == ALIGN_PULSES &&
      gap_cnt >= ALIGN_GAP_CYCLES)
    else fail_now($sformatf("mismatch align pulses before done: got %h, expected %h",
                            $sampled(align_cnt), ALIGN_PULSES));

  done_levels: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    rx_reset_sequence_done |-> !rx_reset && !pll_areset && !rx_channel_data_align)
    else fail_now("Receiver control levels were wrong while done was high");

  rx_word_check: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    tbi_rx_d == model_rx)
    else fail_now($sformatf("mismatch tbi_rx_d: got %h, expected %h",
                            $sampled(tbi_rx_d), $sampled(model_rx)));

  // Select follows rev_loopback_ena in the same cycle
  tx_word_check: assert property (@(posedge ref_clk) disable iff (reset_ref_clk_int)
    tx_word_lvds == (rev_loopback_ena ? model_loop : model_flip))
    else fail_now($sformatf("mismatch tx_word_lvds: got %h, expected %h",
                            $sampled(tx_word_lvds),
                            $sampled(rev_loopback_ena) ? $sampled(model_loop)
                                                       : $sampled(model_flip)));

endmodule

/* build.f */
design/pma_pkg.sv
design/lvds_ctrl_if.sv
design/seq_timer.sv
design/lvds_reset_sequencer.sv
design/tbi_rx_path.sv
design/tbi_tx_path.sv
design/lvds_pma_top.sv
bench/tb_lvds_pma.sv

/* Bender.yml */
package:
  name: lvds_pma

sources:
  # Design, package and interface first
  - files:
      - design/pma_pkg.sv
      - design/lvds_ctrl_if.sv
      - design/seq_timer.sv
      - design/lvds_reset_sequencer.sv
      - design/tbi_rx_path.sv
      - design/tbi_tx_path.sv
      - design/lvds_pma_top.sv

  # Testbench, top module tb_lvds_pma
  - target: test
    files:
      - bench/tb_lvds_pma.sv
